// File: verilog/id_pkg.sv
package id_pkg;

    ////////////////////////////////////////
    // instruction classes
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_ALU     = 3'd0,
        OP_ALUI    = 3'd1,
        OP_LOAD    = 3'd2,
        OP_STORE   = 3'd3,
        OP_BRANCH  = 3'd4,
        OP_JUMP    = 3'd5,
        OP_INVALID = 3'd6
    } op_e;

    // class field position in the instruction word
    localparam int CLS_MSB = 31;
    localparam int CLS_LSB = 29;

    // class field values, 6 and 7 are unused
    localparam logic [2:0] CLS_ALU    = 3'd0;
    localparam logic [2:0] CLS_ALUI   = 3'd1;
    localparam logic [2:0] CLS_LOAD   = 3'd2;
    localparam logic [2:0] CLS_STORE  = 3'd3;
    localparam logic [2:0] CLS_BRANCH = 3'd4;
    localparam logic [2:0] CLS_JUMP   = 3'd5;

    ////////////////////////////////////////
    // exception codes
    ////////////////////////////////////////

    localparam logic [7:0] ECODE_NONE = 8'h00;
    localparam logic [7:0] ECODE_INE  = 8'h0d; // instruction not exist

    // predicted branch type, bits 33:32 of brtype_pcpre
    localparam logic [1:0] BRTYPE_NONE = 2'b00;

    ////////////////////////////////////////
    // instruction buffer
    ////////////////////////////////////////

    localparam int INST_BUF_DEPTH = 16; // entries per bank

endpackage

// File: verilog/id_slot_if.sv
`timescale 1ns/100ps

interface id_slot_if;

    logic              valid;
    logic [31:0]       pc;
    logic [31:0]       ir;
    logic [33:0]       brtype_pcpre; // type in 33:32, predicted pc below
    logic [7:0]        ecode;
    id_pkg::op_e       op;

    // producing stage
    modport src (
        output valid, pc, ir, brtype_pcpre, ecode, op
    );

    // consuming stage
    modport snk (
        input valid, pc, ir, brtype_pcpre, ecode, op
    );

endinterface

// File: verilog/id1_predecode.sv
`timescale 1ns/100ps

module id1_predecode (
    input  logic        clk,
    input  logic        rstn,

    input  logic [31:0] i_pc1,
    input  logic [31:0] i_ir1,
    input  logic [33:0] i_brtype_pcpre_1,
    input  logic [7:0]  i_ecode_1,

    input  logic [31:0] i_pc2,
    input  logic [31:0] i_ir2,
    input  logic [33:0] i_brtype_pcpre_2,
    input  logic [7:0]  i_ecode_2,

    input  logic [1:0]  i_is_valid, // bit 1 is slot 1
    input  logic        i_flush_br,

    id_slot_if.src      o_s1,
    id_slot_if.src      o_s2
);

    // class field to opcode
    function automatic id_pkg::op_e classify(input logic [31:0] ir);
        case (ir[id_pkg::CLS_MSB:id_pkg::CLS_LSB])
            id_pkg::CLS_ALU:    return id_pkg::OP_ALU;
            id_pkg::CLS_ALUI:   return id_pkg::OP_ALUI;
            id_pkg::CLS_LOAD:   return id_pkg::OP_LOAD;
            id_pkg::CLS_STORE:  return id_pkg::OP_STORE;
            id_pkg::CLS_BRANCH: return id_pkg::OP_BRANCH;
            id_pkg::CLS_JUMP:   return id_pkg::OP_JUMP;
            default:            return id_pkg::OP_INVALID;
        endcase
    endfunction

    // an earlier fault from fetch wins over INE
    function automatic logic [7:0] merge_ecode(input id_pkg::op_e op, input logic [7:0] ecode);
        if (op == id_pkg::OP_INVALID && ecode == id_pkg::ECODE_NONE) begin
            return id_pkg::ECODE_INE;
        end
        return ecode;
    endfunction

    id_pkg::op_e op1_d;
    id_pkg::op_e op2_d;

    assign op1_d = classify(i_ir1);
    assign op2_d = classify(i_ir2);

    ////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn || i_flush_br) begin
            o_s1.valid <= 1'b0;
            o_s2.valid <= 1'b0;
        end else begin
            o_s1.valid <= i_is_valid[1];
            o_s2.valid <= i_is_valid[0];
        end
    end

    // payload, follows valid
    always_ff @(posedge clk) begin
        o_s1.pc           <= i_pc1;
        o_s1.ir           <= i_ir1;
        o_s1.brtype_pcpre <= i_brtype_pcpre_1;
        o_s1.op           <= op1_d;
        o_s1.ecode        <= merge_ecode(op1_d, i_ecode_1);

        o_s2.pc           <= i_pc2;
        o_s2.ir           <= i_ir2;
        o_s2.brtype_pcpre <= i_brtype_pcpre_2;
        o_s2.op           <= op2_d;
        o_s2.ecode        <= merge_ecode(op2_d, i_ecode_2);
    end

endmodule

// File: verilog/id_inst_buffer.sv
`timescale 1ns/100ps

module id_inst_buffer #(
    parameter int DEPTH = id_pkg::INST_BUF_DEPTH
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   i_flush_br,
    input  logic   i_stall_issue,

    id_slot_if.snk i_s1,
    id_slot_if.snk i_s2,

    id_slot_if.src o_s1,
    id_slot_if.src o_s2,

    output logic   o_is_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W:0] FULL_LVL = (CNT_W + 1)'(DEPTH - 2);

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] ir;
        logic [33:0] brtype_pcpre;
        logic [7:0]  ecode;
        id_pkg::op_e op;
    } entry_t;

    // index 0 is bank A, 1 is bank B
    entry_t           mem  [2][DEPTH];
    logic [PTR_W-1:0] head [2];
    logic [PTR_W-1:0] tail [2];
    logic [CNT_W-1:0] cnt  [2];
    logic [CNT_W:0]   fill [2]; // count plus entries arriving

    logic             in_ptr;  // bank that takes the next single slot
    logic             out_ptr; // bank holding the oldest entry

    logic [1:0]       wr_en;
    entry_t           wr_data [2];
    logic [1:0]       head_vld;
    logic [1:0]       pop;
    entry_t           rd_1;
    entry_t           rd_2;

    function automatic logic [PTR_W-1:0] next_idx(input logic [PTR_W-1:0] idx);
        if (idx == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    ////////////////////////////////////////
    // write steering
    ////////////////////////////////////////

    entry_t in_1;
    entry_t in_2;

    assign in_1 = '{pc: i_s1.pc, ir: i_s1.ir, brtype_pcpre: i_s1.brtype_pcpre,
                    ecode: i_s1.ecode, op: i_s1.op};
    assign in_2 = '{pc: i_s2.pc, ir: i_s2.ir, brtype_pcpre: i_s2.brtype_pcpre,
                    ecode: i_s2.ecode, op: i_s2.op};

    always_comb begin
        // slot 1 into the bank at in_ptr, slot 2 into the other one
        wr_en[0]   = in_ptr ? i_s2.valid : i_s1.valid;
        wr_en[1]   = in_ptr ? i_s1.valid : i_s2.valid;
        wr_data[0] = in_ptr ? in_2 : in_1;
        wr_data[1] = in_ptr ? in_1 : in_2;
    end

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            fill[b] = {1'b0, cnt[b]} + (CNT_W + 1)'(wr_en[b]);
        end
    end

    // leaves room for the pair still sitting in ID1
    assign o_is_full = (fill[0] >= FULL_LVL) || (fill[1] >= FULL_LVL);

    ////////////////////////////////////////
    // read side
    ////////////////////////////////////////

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            head_vld[b] = (cnt[b] != '0);
        end
    end

    assign rd_1 = mem[out_ptr][head[out_ptr]];
    assign rd_2 = mem[!out_ptr][head[!out_ptr]];

    always_comb begin
        o_s1.valid        = head_vld[out_ptr];
        o_s1.pc           = rd_1.pc;
        o_s1.ir           = rd_1.ir;
        o_s1.brtype_pcpre = rd_1.brtype_pcpre;
        o_s1.ecode        = rd_1.ecode;
        o_s1.op           = rd_1.op;

        o_s2.valid        = head_vld[out_ptr] && head_vld[!out_ptr];
        o_s2.pc           = rd_2.pc;
        o_s2.ir           = rd_2.ir;
        o_s2.brtype_pcpre = rd_2.brtype_pcpre;
        o_s2.ecode        = rd_2.ecode;
        o_s2.op           = rd_2.op;
    end

    always_comb begin
        pop           = 2'b00;
        pop[out_ptr]  = !i_stall_issue && o_s1.valid;
        pop[!out_ptr] = !i_stall_issue && o_s2.valid;
    end

    ////////////////////////////////////////
    // queue state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn || i_flush_br) begin
            for (int b = 0; b < 2; b++) begin
                head[b] <= '0;
                tail[b] <= '0;
                cnt[b]  <= '0;
            end
            in_ptr  <= 1'b0;
            out_ptr <= 1'b0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (wr_en[b]) tail[b] <= next_idx(tail[b]);
                if (pop[b]) head[b] <= next_idx(head[b]);
                cnt[b] <= cnt[b] + CNT_W'(wr_en[b]) - CNT_W'(pop[b]);
            end
            if (i_s1.valid != i_s2.valid) in_ptr <= !in_ptr; // single slot
            if (pop[0] != pop[1]) out_ptr <= !out_ptr;       // one entry left
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (wr_en[b]) begin
                mem[b][tail[b]] <= wr_data[b];
            end
        end
    end

endmodule

// File: verilog/id2_decode.sv
`timescale 1ns/100ps

module id2_decode (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_flush_br,
    input  logic        i_stall_issue,

    id_slot_if.snk      i_s1,
    id_slot_if.snk      i_s2,

    output logic [31:0] o_pc1,
    output logic [31:0] o_ir1,
    output logic [7:0]  o_ecode_1,
    output id_pkg::op_e o_op1,
    output logic [4:0]  o_rd1,
    output logic [4:0]  o_rj1,
    output logic [4:0]  o_rk1,
    output logic        o_mispredict_1,

    output logic [31:0] o_pc2,
    output logic [31:0] o_ir2,
    output logic [7:0]  o_ecode_2,
    output id_pkg::op_e o_op2,
    output logic [4:0]  o_rd2,
    output logic [4:0]  o_rj2,
    output logic [4:0]  o_rk2,
    output logic        o_mispredict_2,

    output logic [1:0]  o_is_valid,
    output logic        o_id_status
);

    // branch target check against the fetch prediction
    function automatic logic mispredict(input logic [31:0] pc, input logic [31:0] ir,
                                        input logic [33:0] bp, input id_pkg::op_e op);
        logic [31:0] target;
        target = pc + {{14{ir[25]}}, ir[25:10], 2'b00};
        if (op == id_pkg::OP_BRANCH || op == id_pkg::OP_JUMP) begin
            return target != bp[31:0];
        end
        return bp[33:32] != id_pkg::BRTYPE_NONE; // predicted taken on a non-branch
    endfunction

    ////////////////////////////////////////
    // control, held under stall
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn || i_flush_br) begin
            o_is_valid     <= 2'b00;
            o_mispredict_1 <= 1'b0;
            o_mispredict_2 <= 1'b0;
        end else if (!i_stall_issue) begin
            o_is_valid     <= {i_s1.valid, i_s2.valid};
            o_mispredict_1 <= i_s1.valid &&
                              mispredict(i_s1.pc, i_s1.ir, i_s1.brtype_pcpre, i_s1.op);
            o_mispredict_2 <= i_s2.valid &&
                              mispredict(i_s2.pc, i_s2.ir, i_s2.brtype_pcpre, i_s2.op);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall_issue) begin
            o_pc1     <= i_s1.pc;
            o_ir1     <= i_s1.ir;
            o_ecode_1 <= i_s1.ecode;
            o_op1     <= i_s1.op;
            o_pc2     <= i_s2.pc;
            o_ir2     <= i_s2.ir;
            o_ecode_2 <= i_s2.ecode;
            o_op2     <= i_s2.op;
        end
    end

    // register fields straight from the held word
    assign o_rd1 = o_ir1[4:0];
    assign o_rj1 = o_ir1[9:5];
    assign o_rk1 = o_ir1[14:10];
    assign o_rd2 = o_ir2[4:0];
    assign o_rj2 = o_ir2[9:5];
    assign o_rk2 = o_ir2[14:10];

    assign o_id_status = |o_is_valid;

endmodule

// File: verilog/id_frontend_top.sv
`timescale 1ns/100ps

module id_frontend_top #(
    parameter int DEPTH = id_pkg::INST_BUF_DEPTH
) (
    input  logic        clk,
    input  logic        rstn,

    input  logic [31:0] i_pc1,
    input  logic [31:0] i_ir1,
    input  logic [33:0] i_brtype_pcpre_1,
    input  logic [7:0]  i_ecode_1,
    input  logic [31:0] i_pc2,
    input  logic [31:0] i_ir2,
    input  logic [33:0] i_brtype_pcpre_2,
    input  logic [7:0]  i_ecode_2,
    input  logic [1:0]  i_is_valid,
    input  logic        i_flush_br,
    input  logic        i_stall_issue,

    output logic [31:0] o_pc1,
    output logic [31:0] o_ir1,
    output logic [7:0]  o_ecode_1,
    output id_pkg::op_e o_op1,
    output logic [4:0]  o_rd1,
    output logic [4:0]  o_rj1,
    output logic [4:0]  o_rk1,
    output logic        o_mispredict_1,
    output logic [31:0] o_pc2,
    output logic [31:0] o_ir2,
    output logic [7:0]  o_ecode_2,
    output id_pkg::op_e o_op2,
    output logic [4:0]  o_rd2,
    output logic [4:0]  o_rj2,
    output logic [4:0]  o_rk2,
    output logic        o_mispredict_2,
    output logic [1:0]  o_is_valid,
    output logic        o_id_status,
    output logic        o_is_full
);

    id_slot_if id1_s1 ();
    id_slot_if id1_s2 ();
    id_slot_if buf_s1 ();
    id_slot_if buf_s2 ();

    id1_predecode u_id1 (
        .clk(clk), .rstn(rstn),
        .i_pc1(i_pc1), .i_ir1(i_ir1),
        .i_brtype_pcpre_1(i_brtype_pcpre_1), .i_ecode_1(i_ecode_1),
        .i_pc2(i_pc2), .i_ir2(i_ir2),
        .i_brtype_pcpre_2(i_brtype_pcpre_2), .i_ecode_2(i_ecode_2),
        .i_is_valid(i_is_valid), .i_flush_br(i_flush_br),
        .o_s1(id1_s1.src), .o_s2(id1_s2.src)
    );

    id_inst_buffer #(.DEPTH(DEPTH)) u_buf (
        .clk(clk), .rstn(rstn),
        .i_flush_br(i_flush_br), .i_stall_issue(i_stall_issue),
        .i_s1(id1_s1.snk), .i_s2(id1_s2.snk),
        .o_s1(buf_s1.src), .o_s2(buf_s2.src),
        .o_is_full(o_is_full)
    );

    id2_decode u_id2 (
        .clk(clk), .rstn(rstn),
        .i_flush_br(i_flush_br), .i_stall_issue(i_stall_issue),
        .i_s1(buf_s1.snk), .i_s2(buf_s2.snk),
        .o_pc1(o_pc1), .o_ir1(o_ir1), .o_ecode_1(o_ecode_1), .o_op1(o_op1),
        .o_rd1(o_rd1), .o_rj1(o_rj1), .o_rk1(o_rk1), .o_mispredict_1(o_mispredict_1),
        .o_pc2(o_pc2), .o_ir2(o_ir2), .o_ecode_2(o_ecode_2), .o_op2(o_op2),
        .o_rd2(o_rd2), .o_rj2(o_rj2), .o_rk2(o_rk2), .o_mispredict_2(o_mispredict_2),
        .o_is_valid(o_is_valid), .o_id_status(o_id_status)
    );

endmodule

// File: sim/id_frontend_asserts.sv
`timescale 1ns/100ps

module id_frontend_asserts #(
    parameter int DEPTH = id_pkg::INST_BUF_DEPTH,
    parameter int CNT_W = $clog2(DEPTH + 1)
) (
    input logic             clk,
    input logic             rstn,
    input logic             i_flush_br,
    input logic [CNT_W-1:0] i_cnt_a,
    input logic [CNT_W-1:0] i_cnt_b,
    input logic             i_is_full
);

    localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(DEPTH);
    localparam logic [CNT_W-1:0] ONE     = CNT_W'(1);

    ////////////////////////////////////////
    // bank counts
    ////////////////////////////////////////

    count_in_range: assert property (@(posedge clk) disable iff (!rstn)
        (i_cnt_a <= MAX_CNT) && (i_cnt_b <= MAX_CNT))
        else $error("bank count above DEPTH");

    // program order alternates, so the banks stay balanced
    count_balance: assert property (@(posedge clk) disable iff (!rstn)
        (i_cnt_a <= i_cnt_b + ONE) && (i_cnt_b <= i_cnt_a + ONE))
        else $error("bank counts differ by more than one");

    flush_clears: assert property (@(posedge clk) disable iff (!rstn)
        i_flush_br |=> (i_cnt_a == '0) && (i_cnt_b == '0))
        else $error("bank counts not cleared after flush");

    full_after_reset: assert property (@(posedge clk)
        !rstn |=> !i_is_full)
        else $error("o_is_full high after reset");

endmodule

bind id_inst_buffer id_frontend_asserts #(.DEPTH(DEPTH), .CNT_W(CNT_W)) u_asserts (
    .clk(clk), .rstn(rstn), .i_flush_br(i_flush_br),
    .i_cnt_a(cnt[0]), .i_cnt_b(cnt[1]), .i_is_full(o_is_full)
);

// File: sim/tb_id_frontend.sv
`timescale 1ns/100ps

module tb_id_frontend;

    localparam int DEPTH      = id_pkg::INST_BUF_DEPTH;
    localparam int NUM_CYCLES = 2000;
    localparam int DRAIN_MAX  = 8 * DEPTH;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] ir;
        id_pkg::op_e op;
        logic [7:0]  ecode;
        logic        mp; // expected mispredict
    } slot_t;

    logic        clk = 1'b0;
    logic        rstn;
    logic [31:0] i_pc1, i_ir1, i_pc2, i_ir2;
    logic [33:0] i_brtype_pcpre_1, i_brtype_pcpre_2;
    logic [7:0]  i_ecode_1, i_ecode_2;
    logic [1:0]  i_is_valid;
    logic        i_flush_br, i_stall_issue;
    logic [31:0] o_pc1, o_ir1, o_pc2, o_ir2;
    logic [7:0]  o_ecode_1, o_ecode_2;
    id_pkg::op_e o_op1, o_op2;
    logic [4:0]  o_rd1, o_rj1, o_rk1, o_rd2, o_rj2, o_rk2;
    logic        o_mispredict_1, o_mispredict_2, o_id_status, o_is_full;
    logic [1:0]  o_is_valid;

    logic [31:0] lfsr = 32'd7986;
    slot_t       model [$]; // accepted slots in program order
    slot_t       last1, last2;
    logic [1:0]  last_valid = 2'b00;
    int          errors = 0;
    int          checked = 0;
    int          full_run = 0;

    id_frontend_top #(.DEPTH(DEPTH)) i_id_frontend_top (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////

    function automatic logic step_lfsr();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], step_lfsr()};
        return v;
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic id_pkg::op_e expected_op(input logic [2:0] cls);
        case (cls)
            3'd0:    return id_pkg::OP_ALU;
            3'd1:    return id_pkg::OP_ALUI;
            3'd2:    return id_pkg::OP_LOAD;
            3'd3:    return id_pkg::OP_STORE;
            3'd4:    return id_pkg::OP_BRANCH;
            3'd5:    return id_pkg::OP_JUMP;
            default: return id_pkg::OP_INVALID;
        endcase
    endfunction

    task automatic gen_slot(output logic [31:0] pc, output logic [31:0] ir,
                            output logic [33:0] bp, output logic [7:0] ec, output slot_t e);
        logic [31:0] r;
        logic [31:0] target;
        int          offset; // branch offset in words
        pc = rand_bits(32) & 32'hffff_fffc;
        ir = rand_bits(32);
        r = rand_bits(3);
        ec = id_pkg::ECODE_NONE;
        if (r[2:0] == 3'd0) begin // fault from fetch now and then
            r = rand_bits(8);
            ec = r[7:0];
        end
        offset = $signed(ir[25:10]);
        target = pc + 32'(offset * 4);
        r = rand_bits(2);
        bp[33:32] = r[1:0];
        r = rand_bits(1);
        bp[31:0] = r[0] ? target : rand_bits(32); // right target half the time
        e.pc = pc;
        e.ir = ir;
        e.op = expected_op(ir[31:29]);
        e.ecode = (e.op == id_pkg::OP_INVALID && ec == id_pkg::ECODE_NONE) ? id_pkg::ECODE_INE : ec;
        if (e.op == id_pkg::OP_BRANCH || e.op == id_pkg::OP_JUMP) e.mp = (target != bp[31:0]);
        else e.mp = (bp[33:32] != 2'b00);
    endtask

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_op(input string name, input id_pkg::op_e exp, input id_pkg::op_e act);
        if (exp !== act) begin
            $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_ecode(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_slot(input string sfx, input slot_t e, input logic [31:0] pc,
                              input logic [31:0] ir, input id_pkg::op_e op,
                              input logic [7:0] ec, input logic [4:0] rd, input logic [4:0] rj,
                              input logic [4:0] rk, input logic mp);
        check_word({"o_pc", sfx}, e.pc, pc);
        check_word({"o_ir", sfx}, e.ir, ir);
        check_op({"o_op", sfx}, e.op, op);
        check_ecode({"o_ecode_", sfx}, e.ecode, ec);
        check_reg({"o_rd", sfx}, e.ir[4:0], rd);
        check_reg({"o_rj", sfx}, e.ir[9:5], rj);
        check_reg({"o_rk", sfx}, e.ir[14:10], rk);
        check_flag({"o_mispredict_", sfx}, e.mp, mp);
    endtask

    task automatic take_expected(output slot_t e, output logic found);
        found = (model.size() != 0);
        e = '0;
        if (found) begin
            e = model.pop_front();
            checked++;
        end else begin
            $display("an instruction came out that was never sent or was flushed at %0t", $time);
            errors++;
        end
    endtask

    // called on the falling edge where stall and flush still hold last cycle's values
    task automatic check_outputs();
        logic found;
        if (i_flush_br) begin
            check_flag("o_is_valid", 1'b0, |o_is_valid);
        end else if (i_stall_issue) begin // outputs must hold
            check_flag("o_is_valid[1]", last_valid[1], o_is_valid[1]);
            check_flag("o_is_valid[0]", last_valid[0], o_is_valid[0]);
            if (o_is_valid[1]) check_slot("1", last1, o_pc1, o_ir1, o_op1, o_ecode_1,
                                          o_rd1, o_rj1, o_rk1, o_mispredict_1);
            if (o_is_valid[0]) check_slot("2", last2, o_pc2, o_ir2, o_op2, o_ecode_2,
                                          o_rd2, o_rj2, o_rk2, o_mispredict_2);
        end else begin
            if (o_is_valid == 2'b01) begin
                $display("slot 2 is valid while slot 1 is empty at %0t", $time);
                errors++;
            end
            if (o_is_valid[1]) begin
                take_expected(last1, found);
                if (found) check_slot("1", last1, o_pc1, o_ir1, o_op1, o_ecode_1,
                                      o_rd1, o_rj1, o_rk1, o_mispredict_1);
            end
            if (o_is_valid[0]) begin
                take_expected(last2, found);
                if (found) check_slot("2", last2, o_pc2, o_ir2, o_op2, o_ecode_2,
                                      o_rd2, o_rj2, o_rk2, o_mispredict_2);
            end
        end
        check_flag("o_id_status", |o_is_valid, o_id_status);
        last_valid = o_is_valid;
        if (o_is_full && !i_stall_issue) full_run++;
        else if (!o_is_full) full_run = 0;
        if (full_run == 4 * DEPTH + 1) begin
            $display("o_is_full stayed high for more than %0d cycles without stall", 4 * DEPTH);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic drive_inputs(input logic send);
        logic [31:0] r;
        slot_t       e1;
        slot_t       e2;
        r = rand_bits(4);
        i_stall_issue = send && (r[3:0] < 4'd5); // about 30 percent
        r = rand_bits(7);
        i_flush_br = send && (r[6:0] == 7'd0);
        r = rand_bits(2);
        case (r[1:0])
            2'd0:    i_is_valid = 2'b00;
            2'd1:    i_is_valid = 2'b10;
            default: i_is_valid = 2'b11;
        endcase
        if (!send || o_is_full) i_is_valid = 2'b00;
        gen_slot(i_pc1, i_ir1, i_brtype_pcpre_1, i_ecode_1, e1);
        gen_slot(i_pc2, i_ir2, i_brtype_pcpre_2, i_ecode_2, e2);
        if (i_flush_br) begin
            model.delete(); // pair at the flush edge is dropped too
        end else begin
            if (i_is_valid[1]) model.push_back(e1);
            if (i_is_valid[0]) model.push_back(e2);
        end
    endtask

    initial begin
        rstn = 1'b0;
        {i_pc1, i_ir1, i_pc2, i_ir2} = '0;
        {i_brtype_pcpre_1, i_brtype_pcpre_2, i_ecode_1, i_ecode_2} = '0;
        i_is_valid = 2'b00;
        i_flush_br = 1'b0;
        i_stall_issue = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_flag("o_is_valid", 1'b0, |o_is_valid);
        check_flag("o_is_full", 1'b0, o_is_full);
        check_flag("o_id_status", 1'b0, o_id_status);
        check_flag("o_mispredict_1", 1'b0, o_mispredict_1);
        check_flag("o_mispredict_2", 1'b0, o_mispredict_2);
        rstn = 1'b1;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(negedge clk);
            check_outputs();
            drive_inputs(1'b1);
        end
        // drain with no stall and no new input
        for (int c = 0; c < DRAIN_MAX && model.size() != 0; c++) begin
            @(negedge clk);
            check_outputs();
            drive_inputs(1'b0);
        end
        if (model.size() != 0) begin
            $display("%0d instructions never reached the outputs", model.size());
            errors++;
        end
        repeat (4) begin
            @(negedge clk);
            check_outputs();
            drive_inputs(1'b0);
        end
        $display("%0d instructions checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(NUM_CYCLES * 20 * 10);
        $display("watchdog expired after %0d cycles, the run did not finish", NUM_CYCLES * 20);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: vlog.f
verilog/id_pkg.sv
verilog/id_slot_if.sv
verilog/id1_predecode.sv
verilog/id_inst_buffer.sv
verilog/id2_decode.sv
verilog/id_frontend_top.sv
sim/id_frontend_asserts.sv
sim/tb_id_frontend.sv

// File: Makefile
# Verilator build and run for the decode front end

VERILATOR ?= verilator
TOP       ?= tb_id_frontend
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
